// ==== logic/vga_text_pkg.sv ====
`default_nettype none

package vga_text_pkg;

   localparam int CELL_BITS   = 4;   // 16x16 pixel cells
   localparam int COORD_W     = 10;
   localparam int GLYPH_ROWS  = 8;
   localparam int GLYPH_COUNT = 15;
   localparam int CELL_IDX_W  = COORD_W - CELL_BITS;

   localparam string FONT_FILE = "logic/font_glyphs.hex";

   typedef logic [CELL_IDX_W-1:0] cell_idx_t;

   // text regions in cell units
   localparam cell_idx_t SEP_ROW          = 6'd5;
   localparam cell_idx_t SEP_COL_LAST     = 6'd39;
   localparam cell_idx_t DATE_ROW         = 6'd7;
   localparam cell_idx_t DATE_COL_FIRST   = 6'd8;
   localparam cell_idx_t DATE_COL_LAST    = 6'd17;
   localparam cell_idx_t ALARM_ROW        = 6'd14;
   localparam cell_idx_t ALARM_COL_FIRST  = 6'd17;
   localparam cell_idx_t ALARM_COL_LAST   = 6'd24;
   localparam cell_idx_t TIME_ROW         = 6'd15;
   localparam cell_idx_t TIMER_ROW        = 6'd24;
   localparam cell_idx_t DIGITS_COL_FIRST = 6'd9;   // shared by time and timer
   localparam cell_idx_t DIGITS_COL_LAST  = 6'd16;

   typedef logic [2:0] rgb_t;

   localparam rgb_t RGB_BLACK = 3'b000;
   localparam rgb_t RGB_WHITE = 3'b111;
   localparam rgb_t RGB_GREEN = 3'b010;
   localparam rgb_t RGB_RED   = 3'b100;

   // digits first so a bcd value is its own code
   typedef enum logic [3:0] {
      GL_0, GL_1, GL_2, GL_3, GL_4, GL_5, GL_6, GL_7, GL_8, GL_9,
      GL_COLON, GL_SLASH, GL_DASH, GL_STAR, GL_BLANK
   } glyph_t;

   typedef enum logic [2:0] {
      REG_NONE, REG_SEP, REG_DATE, REG_TIME, REG_TIMER, REG_ALARM
   } region_t;

   typedef struct packed {
      logic [COORD_W-1:0] x;
      logic [COORD_W-1:0] y;
   } pixel_pos_t;

   typedef struct packed {
      logic [3:0] tens;
      logic [3:0] units;
   } bcd2_t;

   typedef struct packed {
      bcd2_t hours;
      bcd2_t minutes;
      bcd2_t seconds;
   } hms_t;

   typedef struct packed {
      bcd2_t day;
      bcd2_t month;
      bcd2_t year;   // last two digits only
   } date_t;

   typedef struct packed {
      region_t    region;
      glyph_t     glyph;
      logic [2:0] glyph_row;
      logic [2:0] bit_col;
   } tile_req_t;

   typedef struct packed {
      region_t    region;
      logic [7:0] font_row;
      logic [2:0] bit_col;
   } tile_px_t;

endpackage

`default_nettype wire

// ==== logic/text_tile_decoder.sv ====
`default_nettype none

module text_tile_decoder
   import vga_text_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire pixel_pos_t  pix,
   input  wire hms_t        clock_time,
   input  wire hms_t        timer_time,
   input  wire date_t       date,
   output tile_req_t        tile
);

   cell_idx_t col;
   cell_idx_t row;
   cell_idx_t digit_off;
   cell_idx_t date_off;
   tile_req_t tile_d;

   // HH:MM:SS laid out from the first digit column
   function automatic glyph_t hms_glyph(input cell_idx_t off, input hms_t t);
      glyph_t g;
      case (off)
         6'd0:    g = glyph_t'(t.hours.tens);
         6'd1:    g = glyph_t'(t.hours.units);
         6'd3:    g = glyph_t'(t.minutes.tens);
         6'd4:    g = glyph_t'(t.minutes.units);
         6'd6:    g = glyph_t'(t.seconds.tens);
         6'd7:    g = glyph_t'(t.seconds.units);
         default: g = GL_COLON;   // offsets 2 and 5
      endcase
      return g;
   endfunction

   // dd/mm/20yy
   function automatic glyph_t date_glyph(input cell_idx_t off, input date_t d);
      glyph_t g;
      case (off)
         6'd0:       g = glyph_t'(d.day.tens);
         6'd1:       g = glyph_t'(d.day.units);
         6'd3:       g = glyph_t'(d.month.tens);
         6'd4:       g = glyph_t'(d.month.units);
         6'd6:       g = GL_2;
         6'd7:       g = GL_0;
         6'd8:       g = glyph_t'(d.year.tens);
         6'd9:       g = glyph_t'(d.year.units);
         default:    g = GL_SLASH;
      endcase
      return g;
   endfunction

   assign col       = pix.x[COORD_W-1:CELL_BITS];
   assign row       = pix.y[COORD_W-1:CELL_BITS];
   assign digit_off = col - DIGITS_COL_FIRST;
   assign date_off  = col - DATE_COL_FIRST;

   always_comb
   begin
      tile_d.region    = REG_NONE;
      tile_d.glyph     = GL_BLANK;
      tile_d.glyph_row = pix.y[CELL_BITS-1:1];   // each font row spans two lines
      tile_d.bit_col   = pix.x[CELL_BITS-1:1];   // font bits are two pixels wide
      if (row == SEP_ROW && col <= SEP_COL_LAST)
      begin
         tile_d.region = REG_SEP;
         tile_d.glyph  = col[0] ? GL_STAR : GL_DASH;
      end
      else if (row == TIME_ROW && col >= DIGITS_COL_FIRST && col <= DIGITS_COL_LAST)
      begin
         tile_d.region = REG_TIME;
         tile_d.glyph  = hms_glyph(digit_off, clock_time);
      end
      else if (row == TIMER_ROW && col >= DIGITS_COL_FIRST && col <= DIGITS_COL_LAST)
      begin
         tile_d.region = REG_TIMER;
         tile_d.glyph  = hms_glyph(digit_off, timer_time);
      end
      else if (row == DATE_ROW && col >= DATE_COL_FIRST && col <= DATE_COL_LAST)
      begin
         tile_d.region = REG_DATE;
         tile_d.glyph  = date_glyph(date_off, date);
      end
      else if (row == ALARM_ROW && col >= ALARM_COL_FIRST && col <= ALARM_COL_LAST)
      begin
         tile_d.region = REG_ALARM;
         tile_d.glyph  = col[0] ? GL_BLANK : GL_STAR;   // banner of stars
      end
   end

   always_ff @(posedge clk)
   begin
      tile <= tile_d;
      if (!rst_n)
      begin
         tile.region <= REG_NONE;
      end
   end

endmodule

`default_nettype wire

// ==== logic/font_glyph_rom.sv ====
`default_nettype none

module font_glyph_rom
   import vga_text_pkg::*;
(
   input  wire             clk,
   input  wire             rst_n,
   input  wire tile_req_t  tile,
   output tile_px_t        px
);

   localparam int DEPTH  = GLYPH_COUNT * GLYPH_ROWS;
   localparam int ADDR_W = $clog2(DEPTH);

   logic [7:0]        font_mem [0:DEPTH-1];
   logic [ADDR_W-1:0] rom_addr;

   initial
   begin
      $readmemh(FONT_FILE, font_mem);
   end

   // glyph code selects the block of 8 rows
   assign rom_addr = {tile.glyph, tile.glyph_row};

   always_ff @(posedge clk)
   begin
      px.font_row <= font_mem[rom_addr];
      px.bit_col  <= tile.bit_col;   // travels with its row
      px.region   <= tile.region;
      if (!rst_n)
      begin
         px.region <= REG_NONE;
      end
   end

endmodule

`default_nettype wire

// ==== logic/text_colorizer.sv ====
`default_nettype none

module text_colorizer
   import vga_text_pkg::*;
(
   input  wire            clk,
   input  wire            rst_n,
   input  wire tile_px_t  px,
   input  wire            off_alarma,
   input  wire            on_alarma,
   output rgb_t           text_rgb,
   output logic           text_on
);

   logic fg;
   rgb_t rgb_d;

   // column 0 is the msb of the font row
   assign fg = px.font_row[~px.bit_col];

   always_comb
   begin
      case (px.region)
         REG_SEP:
            rgb_d = fg ? RGB_GREEN : RGB_WHITE;
         REG_DATE, REG_TIME, REG_TIMER:
            rgb_d = fg ? RGB_WHITE : RGB_BLACK;
         REG_ALARM:
         begin
            if (fg && off_alarma)
               rgb_d = RGB_GREEN;   // off level wins
            else if (fg && on_alarma)
               rgb_d = RGB_RED;
            else
               rgb_d = RGB_BLACK;
         end
         default:
            rgb_d = RGB_BLACK;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         text_rgb <= RGB_BLACK;
         text_on  <= 1'b0;
      end
      else
      begin
         text_rgb <= rgb_d;
         text_on  <= (px.region != REG_NONE);
      end
   end

endmodule

`default_nettype wire

// ==== logic/vga_text.sv ====
`default_nettype none

module vga_text
   import vga_text_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire pixel_pos_t  pix,
   input  wire hms_t        clock_time,
   input  wire hms_t        timer_time,
   input  wire date_t       date,
   input  wire              off_alarma,
   input  wire              on_alarma,
   output rgb_t             text_rgb,
   output logic             text_on
);

   tile_req_t tile;   // decoder to rom
   tile_px_t  px;     // rom to colouriser

   text_tile_decoder u_decoder (
      .clk        (clk),
      .rst_n      (rst_n),
      .pix        (pix),
      .clock_time (clock_time),
      .timer_time (timer_time),
      .date       (date),
      .tile       (tile)
   );

   font_glyph_rom u_rom (
      .clk   (clk),
      .rst_n (rst_n),
      .tile  (tile),
      .px    (px)
   );

   // alarm levels enter here, one edge before the output
   text_colorizer u_colorizer (
      .clk        (clk),
      .rst_n      (rst_n),
      .px         (px),
      .off_alarma (off_alarma),
      .on_alarma  (on_alarma),
      .text_rgb   (text_rgb),
      .text_on    (text_on)
   );

endmodule

`default_nettype wire

// ==== tb/vga_text_checker.sv ====
`default_nettype none

module vga_text_checker
   import vga_text_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire pixel_pos_t  pix,
   input  wire hms_t        clock_time,
   input  wire hms_t        timer_time,
   input  wire date_t       date,
   input  wire              off_alarma,
   input  wire              on_alarma,
   input  wire rgb_t        text_rgb,
   input  wire              text_on,
   output int               check_count,
   output int               error_count
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int PIPE_LATENCY = 3;   // drive edge to output edge
   localparam int FONT_DEPTH   = GLYPH_COUNT * GLYPH_ROWS;
   localparam int FONT_AW      = $clog2(FONT_DEPTH);

   typedef struct packed {
      region_t region;
      logic    fg;
   } model_px_t;

   logic [7:0] font [0:FONT_DEPTH-1];
   model_px_t  pipe_q [$];   // one entry per sampled pixel
   logic       exp_valid = 1'b0;
   rgb_t       exp_rgb;
   logic       exp_on;

   initial
   begin
      check_count = 0;
      error_count = 0;
      $readmemh(FONT_FILE, font);
   end

   // region and foreground bit of one pixel from the screen layout
   function automatic model_px_t model_pixel(input pixel_pos_t p, input hms_t ct,
                                             input hms_t tt, input date_t d);
      model_px_t  r;
      hms_t       t;
      int         cx;
      int         cy;
      int         code;
      int         row_ix;
      int         hms_seq [8];
      int         date_seq [10];
      logic [7:0] bits;
      logic [7:0] shifted;
      cx       = int'(p.x) >> CELL_BITS;
      cy       = int'(p.y) >> CELL_BITS;
      r.region = REG_NONE;
      code     = int'(GL_BLANK);
      if (cy == int'(SEP_ROW) && cx <= int'(SEP_COL_LAST))
      begin
         r.region = REG_SEP;
         code     = (cx % 2 == 0) ? int'(GL_DASH) : int'(GL_STAR);
      end
      else if ((cy == int'(TIME_ROW) || cy == int'(TIMER_ROW)) &&
               cx >= int'(DIGITS_COL_FIRST) && cx <= int'(DIGITS_COL_LAST))
      begin
         r.region = (cy == int'(TIME_ROW)) ? REG_TIME : REG_TIMER;
         t        = (cy == int'(TIME_ROW)) ? ct : tt;
         hms_seq  = '{int'(t.hours.tens), int'(t.hours.units), int'(GL_COLON),
                      int'(t.minutes.tens), int'(t.minutes.units), int'(GL_COLON),
                      int'(t.seconds.tens), int'(t.seconds.units)};
         foreach (hms_seq[i])
            if (i == cx - int'(DIGITS_COL_FIRST))
               code = hms_seq[i];
      end
      else if (cy == int'(DATE_ROW) && cx >= int'(DATE_COL_FIRST) &&
               cx <= int'(DATE_COL_LAST))
      begin
         r.region = REG_DATE;
         date_seq = '{int'(d.day.tens), int'(d.day.units), int'(GL_SLASH),
                      int'(d.month.tens), int'(d.month.units), int'(GL_SLASH),
                      int'(GL_2), int'(GL_0), int'(d.year.tens), int'(d.year.units)};
         foreach (date_seq[i])
            if (i == cx - int'(DATE_COL_FIRST))
               code = date_seq[i];
      end
      else if (cy == int'(ALARM_ROW) && cx >= int'(ALARM_COL_FIRST) &&
               cx <= int'(ALARM_COL_LAST))
      begin
         r.region = REG_ALARM;
         code     = (cx % 2 == 0) ? int'(GL_STAR) : int'(GL_BLANK);
      end
      row_ix  = (int'(p.y) % (1 << CELL_BITS)) / 2;   // two lines per font row
      bits    = font[FONT_AW'(code * GLYPH_ROWS + row_ix)];
      shifted = bits << ((int'(p.x) % (1 << CELL_BITS)) / 2);
      r.fg    = shifted[7];
      return r;
   endfunction

   function automatic rgb_t model_color(input model_px_t e, input logic alarm_off,
                                        input logic alarm_on);
      rgb_t ink;
      rgb_t paper;
      ink   = RGB_BLACK;
      paper = RGB_BLACK;
      case (e.region)
         REG_SEP:
         begin
            ink   = RGB_GREEN;
            paper = RGB_WHITE;
         end
         REG_DATE, REG_TIME, REG_TIMER:
            ink = RGB_WHITE;
         REG_ALARM:
            if (alarm_off)
               ink = RGB_GREEN;
            else if (alarm_on)
               ink = RGB_RED;
         default:
            ink = RGB_BLACK;
      endcase
      return e.fg ? ink : paper;
   endfunction

   always @(posedge clk)
   begin
      model_px_t head;
      model_px_t tail;
      model_px_t fresh;
      exp_valid = 1'b0;
      if (pipe_q.size() >= PIPE_LATENCY - 1)
      begin
         head      = pipe_q.pop_front();
         exp_valid = 1'b1;
         exp_on    = (head.region != REG_NONE);
         exp_rgb   = model_color(head, off_alarma, on_alarma);   // levels taken at this edge
      end
      fresh = model_pixel(pix, clock_time, timer_time, date);
      if (!rst_n)
      begin
         // every stage drops its region while reset is held
         exp_valid    = 1'b1;
         exp_on       = 1'b0;
         exp_rgb      = RGB_BLACK;
         fresh.region = REG_NONE;
         if (pipe_q.size() > 0)
         begin
            tail        = pipe_q.pop_back();   // the entry in the rom stage
            tail.region = REG_NONE;
            pipe_q.push_back(tail);
         end
      end
      pipe_q.push_back(fresh);
   end

   // outputs are settled by the falling edge
   always @(negedge clk)
   begin
      if (exp_valid)
      begin
         check_count = check_count + 1;
         if (text_on !== exp_on)
         begin
            error_count = error_count + 1;
            $display("** Error at %0t ns: text_on expected %b, got %b",
                     $time, exp_on, text_on);
         end
         if (text_rgb !== exp_rgb)
         begin
            error_count = error_count + 1;
            $display("** Error at %0t ns: text_rgb expected %b, got %b",
                     $time, exp_rgb, text_rgb);
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_vga_text.sv ====
`default_nettype none

module tb_vga_text
   import vga_text_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] LFSR_SEED = 32'h7078f27b;
   localparam logic [31:0] LFSR_POLY = 32'h80200003;
   localparam int SCREEN_W      = 640;
   localparam int SCREEN_H      = 480;
   localparam int CELL_PIXELS   = 1 << (2 * CELL_BITS);
   localparam int DRAIN_CYCLES  = 4;
   localparam int ROUNDS        = 3;
   localparam int DIGIT_CELLS   = int'(DIGITS_COL_LAST) - int'(DIGITS_COL_FIRST) + 3;
   localparam int DATE_CELLS    = int'(DATE_COL_LAST) - int'(DATE_COL_FIRST) + 3;
   localparam int ALARM_CELLS   = int'(ALARM_COL_LAST) - int'(ALARM_COL_FIRST) + 3;
   localparam int RANDOM_PIXELS = 4000;
   localparam int TIMEOUT_CYCLES = (int'(SEP_COL_LAST) + 1) * CELL_PIXELS
                                 + ROUNDS * 2 * DIGIT_CELLS * CELL_PIXELS
                                 + ROUNDS * DATE_CELLS * CELL_PIXELS
                                 + 4 * ALARM_CELLS * CELL_PIXELS
                                 + RANDOM_PIXELS + 200;

   logic        clk;
   logic        rst_n;
   pixel_pos_t  pix;
   hms_t        clock_time;
   hms_t        timer_time;
   date_t       date;
   logic        off_alarma;
   logic        on_alarma;
   rgb_t        text_rgb;
   logic        text_on;
   int          check_count;
   int          error_count;
   int          err_mark;
   int          cycle_count = 0;
   int          round;
   int          combo;
   logic [31:0] lfsr;
   logic [31:0] bits;
   pixel_pos_t  spot;

   vga_text DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .pix        (pix),
      .clock_time (clock_time),
      .timer_time (timer_time),
      .date       (date),
      .off_alarma (off_alarma),
      .on_alarma  (on_alarma),
      .text_rgb   (text_rgb),
      .text_on    (text_on)
   );

   vga_text_checker u_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .pix         (pix),
      .clock_time  (clock_time),
      .timer_time  (timer_time),
      .date        (date),
      .off_alarma  (off_alarma),
      .on_alarma   (on_alarma),
      .text_rgb    (text_rgb),
      .text_on     (text_on),
      .check_count (check_count),
      .error_count (error_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? LFSR_POLY : 32'h0);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic rand_digit(output logic [3:0] d);
      logic [31:0] v;
      do
         take_bits(4, v);
      while (v > 9);   // bcd only
      d = v[3:0];
   endtask

   task automatic random_hms(output hms_t t);
      rand_digit(t.hours.tens);
      rand_digit(t.hours.units);
      rand_digit(t.minutes.tens);
      rand_digit(t.minutes.units);
      rand_digit(t.seconds.tens);
      rand_digit(t.seconds.units);
   endtask

   task automatic random_date(output date_t d);
      rand_digit(d.day.tens);
      rand_digit(d.day.units);
      rand_digit(d.month.tens);
      rand_digit(d.month.units);
      rand_digit(d.year.tens);
      rand_digit(d.year.units);
   endtask

   task automatic random_pixel(output pixel_pos_t p);
      logic [31:0] v;
      do
         take_bits(COORD_W, v);
      while (v >= SCREEN_W);
      p.x = v[COORD_W-1:0];
      do
         take_bits($clog2(SCREEN_H), v);
      while (v >= SCREEN_H);
      p.y = v[COORD_W-1:0];
   endtask

   // every pixel of cells col_first..col_last in one cell row
   task automatic sweep_cells(input int cell_row, input int col_first, input int col_last);
      int x;
      int y;
      for (y = cell_row << CELL_BITS; y < (cell_row + 1) << CELL_BITS; y++)
         for (x = col_first << CELL_BITS; x < (col_last + 1) << CELL_BITS; x++)
         begin
            @(negedge clk);
            pix.x = COORD_W'(x);
            pix.y = COORD_W'(y);
         end
   endtask

   task automatic finish_test(input string name);
      @(negedge clk);
      pix = '0;   // row 0 holds no text
      repeat (DRAIN_CYCLES) @(negedge clk);
      @(posedge clk);
      $display("test %s: %0d errors", name, error_count - err_mark);
      err_mark = error_count;
      @(negedge clk);
   endtask

   initial
   begin
      rst_n      = 1'b0;
      pix        = '0;
      clock_time = '0;
      timer_time = '0;
      date       = '0;
      off_alarma = 1'b0;
      on_alarma  = 1'b0;
      lfsr       = LFSR_SEED;
      err_mark   = 0;

      // separator cell held through reset
      pix.x = COORD_W'(16);
      pix.y = COORD_W'(int'(SEP_ROW) << CELL_BITS);
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      finish_test("reset and pipeline fill");

      sweep_cells(int'(SEP_ROW), 0, int'(SEP_COL_LAST));
      finish_test("separator row");

      for (round = 0; round < ROUNDS; round++)
      begin
         random_hms(clock_time);
         sweep_cells(int'(TIME_ROW), int'(DIGITS_COL_FIRST) - 1, int'(DIGITS_COL_LAST) + 1);
         random_hms(timer_time);
         sweep_cells(int'(TIMER_ROW), int'(DIGITS_COL_FIRST) - 1, int'(DIGITS_COL_LAST) + 1);
      end
      finish_test("time and timer rows");

      for (round = 0; round < ROUNDS; round++)
      begin
         random_date(date);
         sweep_cells(int'(DATE_ROW), int'(DATE_COL_FIRST) - 1, int'(DATE_COL_LAST) + 1);
      end
      finish_test("date row");

      for (combo = 0; combo < 4; combo++)
      begin
         off_alarma = combo[1];
         on_alarma  = combo[0];
         sweep_cells(int'(ALARM_ROW), int'(ALARM_COL_FIRST) - 1, int'(ALARM_COL_LAST) + 1);
      end
      finish_test("alarm banner levels");

      random_hms(clock_time);
      random_hms(timer_time);
      random_date(date);
      repeat (RANDOM_PIXELS)
      begin
         random_pixel(spot);
         take_bits(2, bits);
         @(negedge clk);
         pix        = spot;
         off_alarma = bits[1];
         on_alarma  = bits[0];
      end
      finish_test("random pixels");

      @(posedge clk);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/font_glyphs.hex ====
// one 8-bit glyph row per line, msb is the leftmost pixel
// 8 rows per glyph in code order 0-9, colon, slash, dash, star, blank
3c // 0
66
6e
76
66
66
3c
00
18 // 1
38
18
18
18
18
7e
00
3c // 2
66
06
0c
30
60
7e
00
3c // 3
66
06
1c
06
66
3c
00
0c // 4
1c
3c
6c
7e
0c
0c
00
7e // 5
60
7c
06
06
66
3c
00
3c // 6
60
7c
66
66
66
3c
00
7e // 7
06
0c
18
30
30
30
00
3c // 8
66
66
3c
66
66
3c
00
3c // 9
66
66
3e
06
0c
38
00
00 // colon
18
18
00
18
18
00
00
02 // slash
06
0c
18
30
60
40
00
00 // dash
00
00
7e
00
00
00
00
00 // star
66
3c
ff
3c
66
00
00
00 // blank
00
00
00
00
00
00
00

// ==== compile.f ====
logic/vga_text_pkg.sv
logic/text_tile_decoder.sv
logic/font_glyph_rom.sv
logic/text_colorizer.sv
logic/vga_text.sv
tb/vga_text_checker.sv
tb/tb_vga_text.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_vga_text \
   -f compile.f -o vga_text_sim

./obj_dir/vga_text_sim > sim.log 2>&1
cat sim.log

if grep -qx "TEST RESULT: PASS" sim.log
then
   echo "run_sim: simulation passed"
else
   echo "run_sim: simulation failed"
   exit 1
fi
